//--- hw/vdp_timing_pkg.sv
// Raster geometry and pixel types, imported by the timing, render and top-level units
package vdp_timing_pkg;

  typedef logic [8:0]  raster_t;        // Row or column coordinate
  typedef logic [3:0]  pixel_color_t;   // Palette index
  typedef logic [23:0] rgb_t;           // {R,G,B}

  ////////////////////////////////////////////////////////////////////////////
  // Raster geometry, measured on real hardware

  localparam raster_t NUM_ROWS = 9'd263;
  localparam raster_t NUM_COLS = 9'd260;

  // Render window, 208 x 232 pixels
  localparam raster_t FIRST_ROW_RENDER = 9'd16;
  localparam raster_t LAST_ROW_RENDER  = 9'd247;
  localparam raster_t FIRST_COL_RENDER = 9'd23;
  localparam raster_t LAST_COL_RENDER  = 9'd230;

  // Sync windows
  localparam raster_t FIRST_ROW_VSYNC = 9'd257;  // Three lines
  localparam raster_t LAST_ROW_VSYNC  = 9'd259;
  localparam raster_t FIRST_COL_HSYNC = 9'd240;
  localparam raster_t LAST_COL_HSYNC  = 9'd259;

  // Shown outside the render window
  localparam pixel_color_t BORDER_COLOR = 4'd1;  // Black in the palette

endpackage

//--- hw/vdp_bus_pkg.sv
// CPU bus address map, register fields, wait-state counts and bus data types for the VDP
package vdp_bus_pkg;

  typedef logic [12:0] cpu_addr_t;   // CPU address into the VDP
  typedef logic [7:0]  cpu_data_t;   // CPU data byte
  typedef logic [6:0]  bgm_addr_t;   // BGM word address
  typedef logic [31:0] bgm_word_t;   // Four bytes per BGM word
  typedef logic [2:0]  wait_cnt_t;   // Wait-state down-counter
  typedef logic [3:0]  area_t;       // Upper address bits that pick an area

  ////////////////////////////////////////////////////////////////////////////
  // Address map

  localparam int AREA_MSB = 12;
  localparam int AREA_LSB = 9;

  localparam area_t BGM_AREA = 4'b1000;  // 0x1000 - 0x11FF
  localparam area_t REG_AREA = 4'b1010;  // 0x1400 - 0x15FF

  // Everything but BGM reads back as this
  localparam cpu_data_t UNMAPPED_DATA = 8'hFF;

  ////////////////////////////////////////////////////////////////////////////
  // Wait states, in CP1 pulses

  localparam wait_cnt_t WAIT_BGM_READ   = 3'd3;
  localparam wait_cnt_t WAIT_OTHER_READ = 3'd2;
  localparam wait_cnt_t WAIT_WRITE      = 3'd1;

  // Register 0 bits
  localparam int REG0_BM_ENA   = 0;   // Bitmap on
  localparam int REG0_BM_LORES = 1;   // Low resolution bitmap

  // Register 1 nibbles
  localparam int REG1_BG_LSB = 0;     // Background colour
  localparam int REG1_FG_LSB = 4;     // Foreground colour, hi-res only

endpackage

//--- hw/vdp_cpu_if.sv
// Decoded CPU accesses from the bus unit to the control registers and the BGM
`timescale 1ns/1ps

interface vdp_cpu_if;
  import vdp_bus_pkg::*;

  logic      reg_wr;      // Register area write, level
  logic      bgm_wr;      // BGM write, level
  cpu_addr_t addr;
  cpu_data_t wdata;
  cpu_data_t bgm_rdata;   // Byte at addr, one clock later

  modport bus (
    output reg_wr,
    output bgm_wr,
    output addr,
    output wdata,
    input  bgm_rdata
  );

  modport regs (
    input reg_wr,
    input addr,
    input wdata
  );

  modport bgm (
    input  bgm_wr,
    input  addr,
    input  wdata,
    output bgm_rdata
  );

endinterface

//--- hw/vdp_video_timing.sv
// Raster counter with sync, blanking and data enable outputs plus the register copy strobe
`timescale 1ns/1ps

module vdp_video_timing (
  input  logic                    CLK,
  input  logic                    cpu_wait_cnt_resetting,
  input  logic                    ce,
  output vdp_timing_pkg::raster_t row,
  output vdp_timing_pkg::raster_t col,
  output logic                    in_render,
  output logic                    copy_strobe,
  output logic                    hs,
  output logic                    vs,
  output logic                    vbl,
  output logic                    de
);
  import vdp_timing_pkg::*;

  raster_t row_next;
  raster_t col_next;
  logic    render_row;
  logic    render_col;

  // Wrap column first, then row
  always_comb begin
    row_next = row;
    col_next = col + 1'b1;
    if (col == NUM_COLS - 1'b1) begin
      col_next = '0;
      row_next = (row == NUM_ROWS - 1'b1) ? '0 : row + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      row <= '0;
      col <= '0;
    end else if (ce) begin
      row <= row_next;
      col <= col_next;
    end
  end

  assign render_row = (row >= FIRST_ROW_RENDER) & (row <= LAST_ROW_RENDER);
  assign render_col = (col >= FIRST_COL_RENDER) & (col <= LAST_COL_RENDER);
  assign in_render  = render_row & render_col;

  // Shadow to active copy, first column of VSYNC
  assign copy_strobe = ce & (row == FIRST_ROW_VSYNC) & (col == '0);

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      hs  <= 1'b0;
      vs  <= 1'b0;
      vbl <= 1'b1;  // Row 0 is blanked
      de  <= 1'b0;
    end else if (ce) begin
      hs  <= (col >= FIRST_COL_HSYNC) & (col <= LAST_COL_HSYNC);
      vs  <= (row >= FIRST_ROW_VSYNC) & (row <= LAST_ROW_VSYNC);
      vbl <= ~render_row;
      de  <= in_render;
    end
  end

endmodule

//--- hw/vdp_cpu_bus.sv
// CPU bus unit of the VDP: area decode, WAITB generation and read data return
`timescale 1ns/1ps

module vdp_cpu_bus (
  input  logic                   CLK,
  input  logic                   cpu_wait_cnt_resetting,
  input  logic                   ce,
  input  logic                   cp1_posedge,
  input  logic                   csb,
  input  logic                   rdb,
  input  logic                   wrb,
  input  vdp_bus_pkg::cpu_addr_t a,
  input  vdp_bus_pkg::cpu_data_t db_i,
  output vdp_bus_pkg::cpu_data_t db_o,
  output logic                   db_oe,
  output logic                   waitb,
  vdp_cpu_if.bus                 bus
);
  import vdp_bus_pkg::*;

  logic      sel_bgm;
  logic      sel_reg;
  logic      cpu_rd;
  logic      cpu_wr;
  logic      rdb_d;          // RDB as seen at the last CP1
  logic      rdb_rise;
  wait_cnt_t wait_cnt;
  wait_cnt_t wait_cnt_next;
  logic      wait_rel;       // Low means WAITB drops with CSB
  logic      wait_rel_next;
  wait_cnt_t read_waits;
  wait_cnt_t start_waits;
  cpu_data_t rd_byte;

  ////////////////////////////////////////////////////////////////////////////
  // Decode

  assign sel_bgm = ~csb & (a[AREA_MSB:AREA_LSB] == BGM_AREA);
  assign sel_reg = ~csb & (a[AREA_MSB:AREA_LSB] == REG_AREA);
  assign cpu_rd  = ~(csb | rdb);
  assign cpu_wr  = ~(csb | wrb);

  assign bus.reg_wr = sel_reg & cpu_wr;
  assign bus.bgm_wr = sel_bgm & cpu_wr;
  assign bus.addr   = a;
  assign bus.wdata  = db_i;

  ////////////////////////////////////////////////////////////////////////////
  // Wait states

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      rdb_d <= 1'b1;
    end else if (cp1_posedge) begin
      rdb_d <= rdb;
    end
  end

  assign rdb_rise    = rdb & ~rdb_d;
  assign read_waits  = sel_bgm ? WAIT_BGM_READ : WAIT_OTHER_READ;
  assign start_waits = cpu_rd ? read_waits : WAIT_WRITE;

  // The CP1 pulse that starts an access counts as the first wait
  always_comb begin
    wait_cnt_next = wait_cnt;
    wait_rel_next = wait_rel;
    if (wait_cnt != '0) begin
      wait_cnt_next = wait_cnt - 1'b1;
      if (wait_cnt == wait_cnt_t'(1)) begin
        wait_rel_next = 1'b1;
      end
    end else if (rdb_rise & ~csb) begin
      // Read to write turnaround inside one chip select
      wait_cnt_next = WAIT_WRITE;
      wait_rel_next = 1'b0;
    end else if (~wait_rel & (cpu_rd | cpu_wr)) begin
      wait_cnt_next = start_waits - 1'b1;
      wait_rel_next = (start_waits == wait_cnt_t'(1));
    end else if (~(cpu_rd | cpu_wr)) begin
      wait_rel_next = 1'b0;           // Idle, arm for the next access
    end
  end

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      wait_cnt <= '0;
      wait_rel <= 1'b0;
    end else if (cp1_posedge) begin
      wait_cnt <= wait_cnt_next;
      wait_rel <= wait_rel_next;
    end
  end

  assign waitb = csb | wait_rel;

  ////////////////////////////////////////////////////////////////////////////
  // Read data

  always_ff @(posedge CLK) begin
    if (ce & cpu_rd) begin
      rd_byte <= sel_bgm ? bus.bgm_rdata : UNMAPPED_DATA;
    end
  end

  assign db_o  = rd_byte;
  assign db_oe = cpu_rd;   // Only while CSB and RDB are both low

endmodule

//--- hw/vdp_ctrl_regs.sv
// Control registers 0 and 1 with CPU-written shadows copied to the active set each frame
`timescale 1ns/1ps

module vdp_ctrl_regs (
  input  logic                         CLK,
  input  logic                         cpu_wait_cnt_resetting,
  input  logic                         copy_strobe,
  vdp_cpu_if.regs                      regs,
  output logic                         bm_ena,
  output logic                         bm_lores,
  output vdp_timing_pkg::pixel_color_t bm_bg,
  output vdp_timing_pkg::pixel_color_t bm_fg
);
  import vdp_bus_pkg::*;

  cpu_data_t reg0_sh;   // Shadow copies, CPU side
  cpu_data_t reg1_sh;
  cpu_data_t reg0;      // Active copies, video side
  cpu_data_t reg1;

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      reg0_sh <= '0;
      reg1_sh <= '0;
    end else if (regs.reg_wr) begin
      if (regs.addr[0]) begin
        reg1_sh <= regs.wdata;
      end else begin
        reg0_sh <= regs.wdata;
      end
    end
  end

  // New settings reach the renderer on the next frame
  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      reg0 <= '0;
      reg1 <= '0;
    end else if (copy_strobe) begin
      reg0 <= reg0_sh;
      reg1 <= reg1_sh;
    end
  end

  assign bm_ena   = reg0[REG0_BM_ENA];
  assign bm_lores = reg0[REG0_BM_LORES];
  assign bm_bg    = reg1[REG1_BG_LSB +: 4];
  assign bm_fg    = reg1[REG1_FG_LSB +: 4];

endmodule

//--- hw/vdp_bitmap_render.sv
// Background memory and bitmap renderer, from BGM bytes to 24-bit RGB through the palette
`timescale 1ns/1ps

module vdp_bitmap_render (
  input  logic                         CLK,
  input  logic                         ce,
  input  vdp_timing_pkg::raster_t      row,
  input  vdp_timing_pkg::raster_t      col,
  input  logic                         in_render,
  input  logic                         bm_ena,
  input  logic                         bm_lores,
  input  vdp_timing_pkg::pixel_color_t bm_bg,
  input  vdp_timing_pkg::pixel_color_t bm_fg,
  vdp_cpu_if.bgm                       mem,
  output vdp_timing_pkg::rgb_t         rgb
);
  import vdp_timing_pkg::*;
  import vdp_bus_pkg::*;

  bgm_word_t    bgm [128];
  bgm_addr_t    cpu_word;
  logic [1:0]   cpu_byte;

  logic [4:0]   tile_x;
  logic [4:0]   tile_y;
  bgm_addr_t    fetch_addr;
  bgm_word_t    fetch_word;
  cpu_data_t    fetch_byte;
  logic [3:0]   lo_nib;
  logic [1:0]   hi_bits;
  logic [7:0]   tile_pat;
  pixel_color_t tile_fg;
  logic         tile_load;

  logic [7:0]   shift;          // Leftmost pixel in bit 7
  pixel_color_t cur_fg;
  pixel_color_t cur_bg;
  pixel_color_t pix;
  logic         window_d;
  pixel_color_t out_idx;

  ////////////////////////////////////////////////////////////////////////////
  // BGM, CPU port

  assign cpu_word = mem.addr[8:2];
  assign cpu_byte = mem.addr[1:0];

  always_ff @(posedge CLK) begin
    if (mem.bgm_wr) begin
      bgm[cpu_word][cpu_byte*8 +: 8] <= mem.wdata;
    end
    mem.bgm_rdata <= bgm[cpu_word][cpu_byte*8 +: 8];
  end

  ////////////////////////////////////////////////////////////////////////////
  // BGM, render port

  // 8x8 tiles, two tile rows share a BGM row of 8 words
  assign tile_x     = col[7:3];
  assign tile_y     = row[7:3];
  assign fetch_addr = {tile_y[4:1], tile_x[4:2]};

  always_ff @(posedge CLK) begin
    fetch_word <= bgm[fetch_addr];
  end

  assign fetch_byte = fetch_word[tile_x[1:0]*8 +: 8];

  // Top half of a tile uses the high nibble
  assign lo_nib  = row[3] ? fetch_byte[3:0] : fetch_byte[7:4];
  assign hi_bits = fetch_byte[{~row[3:2], 1'b0} +: 2];

  always_comb begin
    tile_pat = '0;
    tile_fg  = bm_fg;
    if (bm_ena) begin
      if (bm_lores) begin
        if (lo_nib != '0) begin     // Nibble 0 shows the background
          tile_pat = '1;
          tile_fg  = lo_nib;
        end
      end else begin
        tile_pat = {{4{hi_bits[1]}}, {4{hi_bits[0]}}};
      end
    end
  end

  // Mid-tile load, the fetched word is settled by then
  assign tile_load = (col[2:0] == 3'd4);

  always_ff @(posedge CLK) begin
    if (ce) begin
      window_d <= in_render;
      if (tile_load) begin
        shift  <= tile_pat;
        cur_fg <= tile_fg;
        cur_bg <= bm_bg;
      end else begin
        shift <= {shift[6:0], 1'b0};
      end
    end
  end

  assign pix     = shift[7] ? cur_fg : cur_bg;
  assign out_idx = window_d ? pix : BORDER_COLOR;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed palette

  always_comb begin
    case (out_idx)
      4'd0:    rgb = 24'h0000A0;
      4'd1:    rgb = 24'h000000;
      4'd2:    rgb = 24'h0000F5;
      4'd3:    rgb = 24'hA000EB;
      4'd4:    rgb = 24'h00F500;
      4'd5:    rgb = 24'h96EB96;
      4'd6:    rgb = 24'h00EBEB;
      4'd7:    rgb = 24'h00A000;
      4'd8:    rgb = 24'hF50000;
      4'd9:    rgb = 24'hEBA000;
      4'd10:   rgb = 24'hEB00EB;
      4'd11:   rgb = 24'hEB9696;
      4'd12:   rgb = 24'hEBEB00;
      4'd13:   rgb = 24'hA0A000;
      4'd14:   rgb = 24'h969696;
      default: rgb = 24'hE1E1E1;  // Index 15, white
    endcase
  end

endmodule

//--- hw/vdp_top.sv
// VDP top level, connects timing, CPU bus, registers and renderer behind plain ports
`timescale 1ns/1ps

module vdp_top (
  input  logic                   CLK,
  input  logic                   cpu_wait_cnt_resetting,
  input  logic                   CE,
  input  logic                   CP1_POSEDGE,
  input  logic                   CSB,
  input  logic                   RDB,
  input  logic                   WRB,
  input  vdp_bus_pkg::cpu_addr_t A,
  input  vdp_bus_pkg::cpu_data_t DB_I,
  output vdp_bus_pkg::cpu_data_t DB_O,
  output logic                   DB_OE,
  output logic                   WAITB,
  output logic                   VBL,
  output logic                   DE,
  output logic                   HS,
  output logic                   VS,
  output vdp_timing_pkg::rgb_t   RGB
);
  import vdp_timing_pkg::*;

  raster_t      row;
  raster_t      col;
  logic         in_render;
  logic         copy_strobe;
  logic         bm_ena;
  logic         bm_lores;
  pixel_color_t bm_bg;
  pixel_color_t bm_fg;

  vdp_cpu_if cpu_if ();

  vdp_video_timing u_timing (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .ce                     (CE),
    .row                    (row),
    .col                    (col),
    .in_render              (in_render),
    .copy_strobe            (copy_strobe),
    .hs                     (HS),
    .vs                     (VS),
    .vbl                    (VBL),
    .de                     (DE)
  );

  vdp_cpu_bus u_cpu_bus (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .ce                     (CE),
    .cp1_posedge            (CP1_POSEDGE),
    .csb                    (CSB),
    .rdb                    (RDB),
    .wrb                    (WRB),
    .a                      (A),
    .db_i                   (DB_I),
    .db_o                   (DB_O),
    .db_oe                  (DB_OE),
    .waitb                  (WAITB),
    .bus                    (cpu_if.bus)
  );

  vdp_ctrl_regs u_regs (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .copy_strobe            (copy_strobe),
    .regs                   (cpu_if.regs),
    .bm_ena                 (bm_ena),
    .bm_lores               (bm_lores),
    .bm_bg                  (bm_bg),
    .bm_fg                  (bm_fg)
  );

  vdp_bitmap_render u_render (
    .CLK       (CLK),
    .ce        (CE),
    .row       (row),
    .col       (col),
    .in_render (in_render),
    .bm_ena    (bm_ena),
    .bm_lores  (bm_lores),
    .bm_bg     (bm_bg),
    .bm_fg     (bm_fg),
    .mem       (cpu_if.bgm),
    .rgb       (RGB)
  );

endmodule

//--- verif/vdp_bus_props.sv
// Concurrent checks on the VDP CPU bus unit, bound into every vdp_cpu_bus instance
`timescale 1ns/1ps

module vdp_bus_props (
  input logic                   CLK,
  input logic                   cpu_wait_cnt_resetting,
  input logic                   cp1_posedge,
  input logic                   csb,
  input logic                   rdb,
  input logic                   waitb,
  input vdp_bus_pkg::wait_cnt_t wait_cnt
);
  import vdp_bus_pkg::*;

  // Waits still to run keep WAITB low
  a_wait_hold: assert property (@(posedge CLK) disable iff (cpu_wait_cnt_resetting)
    !csb && (wait_cnt != '0) |-> !waitb) else $error("WAITB high while waits remain");

  a_wait_release: assert property (@(posedge CLK) disable iff (cpu_wait_cnt_resetting)
    cp1_posedge && (wait_cnt == wait_cnt_t'(1)) |=> waitb)
    else $error("WAITB still low after the last wait");

  // A read never ends on the CP1 pulse that starts it
  a_read_waits: assert property (@(posedge CLK) disable iff (cpu_wait_cnt_resetting)
    cp1_posedge && !csb && !rdb && !waitb && (wait_cnt == '0) |=> (csb || !waitb))
    else $error("Read released after a single wait");

endmodule

bind vdp_cpu_bus vdp_bus_props u_bus_props (
  .CLK                    (CLK),
  .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
  .cp1_posedge            (cp1_posedge),
  .csb                    (csb),
  .rdb                    (rdb),
  .waitb                  (waitb),
  .wait_cnt               (wait_cnt)
);

//--- verif/vdp_tb.sv
// VDP testbench: runs CPU accesses and frame checks from the pattern file against vdp_top
`timescale 1ns/1ps

module vdp_tb;
  import vdp_timing_pkg::*;
  import vdp_bus_pkg::*;

  localparam int CYCLES_PER_FRAME = 68380;   // 263 rows of 260 pixels
  localparam int MAX_FRAMES       = 11;      // Eight frames of records plus margin
  localparam int CYCLE_LIMIT      = MAX_FRAMES * CYCLES_PER_FRAME + 20000;
  localparam int MAX_PIX_REPORTS  = 10;

  logic      CLK = 1'b0;
  logic      cpu_wait_cnt_resetting;
  logic      CE;
  logic      CP1_POSEDGE;
  logic      CSB;
  logic      RDB;
  logic      WRB;
  cpu_addr_t A;
  cpu_data_t DB_I;
  cpu_data_t DB_O;
  logic      DB_OE;
  logic      WAITB;
  logic      VBL;
  logic      DE;
  logic      HS;
  logic      VS;
  rgb_t      RGB;

  int        errors = 0;
  int        checks = 0;
  int        cycles = 0;
  int        pulses = 0;
  int        pix_reports = 0;
  logic      counting = 1'b0;
  logic      aligned = 1'b0;       // Set right after a VS falling edge
  cpu_data_t bgm_model [512];

  vdp_top dut (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .CE                     (CE),
    .CP1_POSEDGE            (CP1_POSEDGE),
    .CSB                    (CSB),
    .RDB                    (RDB),
    .WRB                    (WRB),
    .A                      (A),
    .DB_I                   (DB_I),
    .DB_O                   (DB_O),
    .DB_OE                  (DB_OE),
    .WAITB                  (WAITB),
    .VBL                    (VBL),
    .DE                     (DE),
    .HS                     (HS),
    .VS                     (VS),
    .RGB                    (RGB)
  );

  always #20 CLK = ~CLK;

  always @(negedge CLK) CP1_POSEDGE <= ~CP1_POSEDGE;   // Every second clock

  // Wait pulses seen while WAITB is low, plus the run limit
  always @(posedge CLK) begin
    cycles++;
    if (counting && CP1_POSEDGE && !WAITB) pulses++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d errors in %0d checks", cycles, errors, checks);
      $display("Errors found");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [23:0] got, input logic [23:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // CPU accesses

  task automatic cpu_access(input logic is_rd, input cpu_addr_t addr, input cpu_data_t data,
                            input int hold, output cpu_data_t rd_val);
    int exp_waits;
    @(negedge CLK);
    A        = addr;
    DB_I     = data;
    CSB      = 1'b0;
    RDB      = ~is_rd;
    WRB      = is_rd;
    pulses   = 0;
    counting = 1'b1;
    repeat (hold) @(negedge CLK);
    rd_val = DB_O;
    if (is_rd && DB_OE !== 1'b1) begin
      errors++;
      $display("DB_OE not high during a read at t=%0t", $time);
    end
    if (!is_rd && DB_OE !== 1'b0) begin
      errors++;
      $display("DB_OE high during a write at t=%0t", $time);
    end
    counting = 1'b0;
    CSB = 1'b1;
    RDB = 1'b1;
    WRB = 1'b1;
    if (!is_rd) exp_waits = 1;
    else if (addr >= 13'h1000 && addr <= 13'h11FF) exp_waits = 3;   // BGM read
    else exp_waits = 2;
    compare("WAITB pulses", pulses, exp_waits);
    repeat (2) begin
      @(negedge CLK);
      if (WAITB !== 1'b1) begin
        errors++;
        $display("WAITB low while CSB high at t=%0t", $time);
      end
      if (DB_OE !== 1'b0) begin
        errors++;
        $display("DB_OE high while CSB high at t=%0t", $time);
      end
    end
    aligned = 1'b0;
  endtask

  task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data, input int hold);
    cpu_data_t dummy;
    cpu_access(1'b0, addr, data, hold, dummy);
    if (addr >= 13'h1000 && addr <= 13'h11FF) bgm_model[addr[8:0]] = data;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Frame checks, one frame runs from VS fall to VS fall

  task automatic wait_vs_fall();
    logic vs_prev;
    vs_prev = 1'b0;
    forever begin
      @(negedge CLK);
      if (vs_prev && !VS) break;
      vs_prev = VS;
    end
    aligned = 1'b1;
  endtask

  task automatic check_frame(input rgb_t exp_rgb);
    logic vs_prev;
    logic hs_prev;
    logic de_prev;
    logic done;
    int   hs_cnt;
    int   vs_rise;
    int   vs_cycles;
    int   vbl_low;
    int   de_lines;
    int   de_cnt;
    vs_prev = VS;
    hs_prev = HS;
    de_prev = DE;
    done = 1'b0;
    hs_cnt = 0;
    vs_rise = 0;
    vs_cycles = 0;
    vbl_low = 0;
    de_lines = 0;
    de_cnt = 0;
    while (!done) begin
      @(negedge CLK);
      if (HS && !hs_prev) hs_cnt++;
      if (VS && !vs_prev) vs_rise++;
      if (VS) vs_cycles++;
      if (!VBL) vbl_low++;
      if (DE && VBL) begin
        errors++;
        $display("VBL high while DE high at t=%0t", $time);
      end
      if (DE) begin
        if (de_cnt >= 8) begin   // Line start may still hold the old tile
          checks++;
          if (RGB !== exp_rgb) begin
            errors++;
            if (pix_reports < MAX_PIX_REPORTS) begin
              $display("ERR t=%0t RGB got %h exp %h", $time, RGB, exp_rgb);
              pix_reports++;
            end
          end
        end
        de_cnt++;
      end else if (de_prev) begin
        de_lines++;
        compare("DE pixels per line", de_cnt, 208);
        de_cnt = 0;
      end
      done = vs_prev && !VS;
      hs_prev = HS;
      vs_prev = VS;
      de_prev = DE;
    end
    compare("HS pulses", hs_cnt, 263);
    compare("VS pulses", vs_rise, 1);
    compare("VS cycles", vs_cycles, 3 * 260);
    compare("VBL low cycles", vbl_low, 232 * 260);
    compare("DE lines", de_lines, 232);
    aligned = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Pattern file

  initial begin
    int          fd;
    int          n;
    int          i;
    string       line;
    byte         cmd;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    cpu_data_t   rd;
    cpu_addr_t   ra;
    cpu_addr_t   rnd_addrs [$];
    void'($urandom(438));
    cpu_wait_cnt_resetting = 1'b1;
    CE = 1'b1;
    CP1_POSEDGE = 1'b0;
    CSB = 1'b1;
    RDB = 1'b1;
    WRB = 1'b1;
    A = '0;
    DB_I = '0;
    repeat (4) @(negedge CLK);
    cpu_wait_cnt_resetting = 1'b0;
    fd = $fopen("verif/vdp_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Pattern file could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h", cmd, f1, f2, f3);
          case (cmd)
            "W": cpu_write(f1[12:0], f2[7:0], 4);
            "R": begin
              cpu_access(1'b1, f1[12:0], 8'h00, 8, rd);
              compare("DB_O", rd, f2[7:0]);
            end
            "X": begin
              rnd_addrs.delete();
              for (i = 0; i < f1; i++) begin
                ra = 13'h1000 + 13'($urandom % 512);
                cpu_write(ra, 8'($urandom), 4);
                rnd_addrs.push_back(ra);
              end
              foreach (rnd_addrs[k]) begin
                cpu_access(1'b1, rnd_addrs[k], 8'h00, 8, rd);
                compare("DB_O", rd, bgm_model[rnd_addrs[k][8:0]]);
              end
            end
            "B": for (i = 0; i < 512; i++) cpu_write(13'h1000 + 13'(i), f1[7:0], 2);
            "C": begin
              if (!aligned) wait_vs_fall();
              cpu_write(13'h1400, f1[7:0], 2);
              cpu_write(13'h1401, f2[7:0], 2);
              check_frame(f3[23:0]);
            end
            "V": begin
              if (!aligned) wait_vs_fall();
              check_frame(f1[23:0]);
            end
            default: begin
              errors++;
              $display("Unknown pattern record: %s", line);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verif/vdp_patterns.txt
# cmd and hex fields: W addr data | R addr expect | X count | B fill
# C reg0 reg1 rgb_this_frame | V rgb_this_frame
W 1000 a5
W 1001 3c
W 1002 0f
W 11ff 81
R 1000 a5
R 1001 3c
R 1002 0f
R 11ff 81
W 0800 55
R 0800 ff
R 1400 ff
R 1401 ff
R 0000 ff
R 1fff ff
X 8
B 77
C 03 00 0000a0
C 03 52 00a000
B 00
C 01 52 0000f5
B ff
C 00 52 96eb96
V 0000f5

//--- flist.f
hw/vdp_timing_pkg.sv
hw/vdp_bus_pkg.sv
hw/vdp_cpu_if.sv
hw/vdp_video_timing.sv
hw/vdp_cpu_bus.sv
hw/vdp_ctrl_regs.sv
hw/vdp_bitmap_render.sv
hw/vdp_top.sv
verif/vdp_bus_props.sv
verif/vdp_tb.sv
